/* include/bank_params.svh */
/*
 * banked buffer sizing
 * bank count, row address width per bank and word width,
 * shared by the packages and every rtl block of the buffer
 */

`ifndef BANK_PARAMS_SVH
`define BANK_PARAMS_SVH

// number of interleaved banks, power of two
`define BANK_COUNT 4

// row address bits inside one bank, 16 rows
`define ROW_BITS 4

// payload width of one stored word
`define WORD_BITS 16

`endif

/* source/buf_addr_pkg.sv */
/*
 * buffer address types
 * a buffer address is the row above the bank index, so
 * consecutive addresses land in consecutive banks
 */

`default_nettype none

`include "bank_params.svh"

package buf_addr_pkg;

	// low address bits, select the bank
	typedef logic [$clog2(`BANK_COUNT)-1:0] bank_idx_t;

	typedef logic [`ROW_BITS-1:0] row_t; // word within a bank

	// full address, row in the upper bits
	typedef struct packed {
		row_t      row;
		bank_idx_t bank;
	} buf_addr_t;

endpackage

`default_nettype wire

/* source/buf_data_pkg.sv */
/*
 * buffer payload type
 * one word as stored in every bank
 */

`default_nettype none

`include "bank_params.svh"

package buf_data_pkg;

	// stored word, no byte lanes
	typedef logic [`WORD_BITS-1:0] word_t;

endpackage

`default_nettype wire

/* source/bank_router.sv */
/*
 * bank router
 * registers the write and read commands, splits each address
 * into bank and row and decodes the bank into one-hot enables.
 * the read bank index goes on to the read collector
 */

`default_nettype none

`include "bank_params.svh"

module bank_router (
	input  wire                             clk_a,
	input  wire                             rst_n,
	// write command
	input  wire                             wr_en,
	input  wire buf_addr_pkg::buf_addr_t    wr_addr,
	input  wire buf_data_pkg::word_t        wr_data,
	// read command
	input  wire                             rd_en,
	input  wire buf_addr_pkg::buf_addr_t    rd_addr,
	// towards the banks
	output logic [`BANK_COUNT-1:0]          bank_wr_en,
	output buf_addr_pkg::row_t              bank_wr_row,
	output buf_data_pkg::word_t             bank_wr_data,
	output logic [`BANK_COUNT-1:0]          bank_rd_en,
	output buf_addr_pkg::row_t              bank_rd_row,
	// towards the collector
	output logic                            req_valid,
	output buf_addr_pkg::bank_idx_t         req_bank
);

	import buf_addr_pkg::*;

	bank_idx_t              wr_bank, rd_bank; // low address bits
	row_t                   wr_row, rd_row;   // high address bits
	logic [`BANK_COUNT-1:0] wr_dec, rd_dec;   // one-hot, before the register

	assign wr_bank = wr_addr.bank;
	assign wr_row  = wr_addr.row;
	assign rd_bank = rd_addr.bank;
	assign rd_row  = rd_addr.row;

	// a single bit set per enabled command
	always_comb begin
		wr_dec          = '0;
		rd_dec          = '0;
		wr_dec[wr_bank] = wr_en;
		rd_dec[rd_bank] = rd_en;
	end

	// control side, cleared by reset
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			bank_wr_en <= '0;
			bank_rd_en <= '0;
			req_valid  <= 1'b0;
			req_bank   <= '0;
		end else begin
			bank_wr_en <= wr_dec;
			bank_rd_en <= rd_dec;
			req_valid  <= rd_en; // one pulse per read
			if (rd_en)
				req_bank <= rd_bank; // collector needs it one stage later
		end
	end

	// rows and data only load with their command
	always_ff @(posedge clk_a) begin
		if (wr_en) begin
			bank_wr_row  <= wr_row;
			bank_wr_data <= wr_data;
		end
		if (rd_en)
			bank_rd_row <= rd_row;
	end

	// a command never reaches more than one bank
	a_onehot_en: assert property (@(posedge clk_a) disable iff (!rst_n)
		$onehot0(bank_wr_en) && $onehot0(bank_rd_en));

endmodule

`default_nettype wire

/* source/dp_sram_bank.sv */
/*
 * dual-port sram bank
 * one write port and one read port on the same clock,
 * synchronous registered read, read-first on a collision
 */

`default_nettype none

`include "bank_params.svh"

module dp_sram_bank (
	input  wire                         clk_a,
	// write port
	input  wire                         wr_en,
	input  wire buf_addr_pkg::row_t     wr_row,
	input  wire buf_data_pkg::word_t    wr_data,
	// read port
	input  wire                         rd_en,
	input  wire buf_addr_pkg::row_t     rd_row,
	output buf_data_pkg::word_t         rd_data
);

	import buf_addr_pkg::*;
	import buf_data_pkg::*;

	localparam int unsigned ROWS = 2 ** $bits(row_t); // rows in this bank

	// storage array, contents start undefined
	word_t mem [0:ROWS-1];

	// write port
	always_ff @(posedge clk_a) begin
		if (wr_en)
			mem[wr_row] <= wr_data;
	end

	// read port, nonblocking so a same-edge write is not seen
	always_ff @(posedge clk_a) begin
		if (rd_en)
			rd_data <= mem[rd_row]; // holds between reads
	end

	// router must hand over a resolved row with every enable
	a_wr_row_known: assert property (@(posedge clk_a)
		wr_en |-> !$isunknown(wr_row));

	a_rd_row_known: assert property (@(posedge clk_a)
		rd_en |-> !$isunknown(rd_row));

endmodule

`default_nettype wire

/* source/read_collector.sv */
/*
 * read collector
 * follows each read request through the bank stage, then
 * picks the word of the addressed bank into the output
 * register and pulses rd_valid with it
 */

`default_nettype none

`include "bank_params.svh"

module read_collector (
	input  wire                                              clk_a,
	input  wire                                              rst_n,
	// request from the router in the same stage as the bank enables
	input  wire                                              req_valid,
	input  wire buf_addr_pkg::bank_idx_t                     req_bank,
	// registered word of every bank
	input  wire buf_data_pkg::word_t [`BANK_COUNT-1:0]       bank_rd_data,
	// answer
	output logic                                             rd_valid,
	output buf_data_pkg::word_t                              rd_data
);

	import buf_addr_pkg::*;

	logic      req_valid_d; // lined up with the bank read register
	bank_idx_t req_bank_d;

	// delayed one stage to match the bank read latency
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			req_valid_d <= 1'b0;
			req_bank_d  <= '0;
		end else begin
			req_valid_d <= req_valid;
			if (req_valid)
				req_bank_d <= req_bank;
		end
	end

	// single-cycle valid strobe per read
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= req_valid_d;
	end

	// output word loads only when a read completes
	always_ff @(posedge clk_a) begin
		if (req_valid_d)
			rd_data <= bank_rd_data[req_bank_d];
	end

	// nothing enters or leaves while the buffer is held in reset
	a_quiet_in_reset: assert property (@(posedge clk_a)
		!rst_n |-> !req_valid && !rd_valid);

endmodule

`default_nettype wire

/* source/banked_buffer_top.sv */
/*
 * banked dual-port word buffer
 * address interleaved over BANK_COUNT sram banks, one write
 * and one read per cycle, every read answers three cycles later
 */

`default_nettype none

`include "bank_params.svh"

module banked_buffer_top (
	input  wire                             clk_a,
	input  wire                             rst_n,
	// write port
	input  wire                             wr_en,
	input  wire buf_addr_pkg::buf_addr_t    wr_addr,
	input  wire buf_data_pkg::word_t        wr_data,
	// read port
	input  wire                             rd_en,
	input  wire buf_addr_pkg::buf_addr_t    rd_addr,
	output logic                            rd_valid,
	output buf_data_pkg::word_t             rd_data
);

	import buf_addr_pkg::*;
	import buf_data_pkg::*;

	logic [`BANK_COUNT-1:0]  bank_wr_en;   // one-hot per write
	row_t                    bank_wr_row;  // shared by all banks
	word_t                   bank_wr_data;
	logic [`BANK_COUNT-1:0]  bank_rd_en;   // one-hot per read
	row_t                    bank_rd_row;
	logic                    req_valid;
	bank_idx_t               req_bank;
	word_t [`BANK_COUNT-1:0] bank_rd_data; // one word per bank

	bank_router u_router (
		.clk_a        (clk_a),
		.rst_n        (rst_n),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.bank_wr_en   (bank_wr_en),
		.bank_wr_row  (bank_wr_row),
		.bank_wr_data (bank_wr_data),
		.bank_rd_en   (bank_rd_en),
		.bank_rd_row  (bank_rd_row),
		.req_valid    (req_valid),
		.req_bank     (req_bank)
	);

	// one bank per low address value
	for (genvar b = 0; b < `BANK_COUNT; b++) begin : g_bank
		dp_sram_bank u_bank (
			.clk_a   (clk_a),
			.wr_en   (bank_wr_en[b]),
			.wr_row  (bank_wr_row),
			.wr_data (bank_wr_data),
			.rd_en   (bank_rd_en[b]),
			.rd_row  (bank_rd_row),
			.rd_data (bank_rd_data[b])
		);
	end

	read_collector u_collector (
		.clk_a        (clk_a),
		.rst_n        (rst_n),
		.req_valid    (req_valid),
		.req_bank     (req_bank),
		.bank_rd_data (bank_rd_data),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data)
	);

endmodule

`default_nettype wire

/* tb/banked_buffer_tb.sv */
/*
 * banked buffer testbench
 * fills the buffer, reads it back, probes write/read ordering
 * and runs random concurrent traffic against a shadow model
 */

`default_nettype none

`include "bank_params.svh"

module banked_buffer_tb;

	import buf_addr_pkg::*;
	import buf_data_pkg::*;

	localparam int ADDR_W = $bits(buf_addr_t); // 6 bits, 64 words
	localparam int WORDS  = 2 ** ADDR_W;
	localparam int LATENCY = 3;                // rd_en to rd_valid
	localparam int DRAIN_LIMIT = 20;

	logic        clk_a = 1'b0;
	logic        rst_n;
	logic        wr_en;
	buf_addr_t   wr_addr;
	word_t       wr_data;
	logic        rd_en;
	buf_addr_t   rd_addr;
	logic        rd_valid;
	word_t       rd_data;

	int unsigned cycle = 0;        // posedges seen so far
	logic [31:0] rng_state = 32'd8;
	word_t       shadow [0:WORDS-1]; // memory model

	// reads in flight, oldest first
	word_t             exp_data_q [$];
	int unsigned       exp_due_q [$];
	logic [ADDR_W-1:0] exp_addr_q [$];

	banked_buffer_top dut (
		.clk_a    (clk_a),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

	always #2 clk_a = ~clk_a; // period 4

	always @(posedge clk_a) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected word of a read, taken at issue time
	function automatic word_t predict_read(input logic [ADDR_W-1:0] a);
		return shadow[a];
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic verify_strobe(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic verify_latency(input int unsigned got, input int unsigned exp);
		if (got != exp)
			stop_with_failure($sformatf("mismatch rd_valid cycle: got 0x%h expected 0x%h",
				got, exp));
	endtask

	task automatic draw_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// one cycle of stimulus, driven on the falling edge
	task automatic step(input logic do_wr, input logic [ADDR_W-1:0] waddr, input word_t wdata,
		input logic do_rd, input logic [ADDR_W-1:0] raddr);
		@(negedge clk_a);
		if (do_rd) begin
			exp_data_q.push_back(predict_read(raddr)); // before the write, read-first
			exp_due_q.push_back(cycle + LATENCY);
			exp_addr_q.push_back(raddr);
		end
		if (do_wr)
			shadow[waddr] = wdata;
		wr_en   = do_wr;
		wr_addr = waddr;
		wr_data = wdata;
		rd_en   = do_rd;
		rd_addr = raddr;
	endtask

	task automatic idle();
		step(1'b0, '0, '0, 1'b0, '0);
	endtask

	// wait until every read in flight has answered
	task automatic wait_drain();
		int n;
		for (n = 0; n < DRAIN_LIMIT && exp_due_q.size() != 0; n++)
			@(negedge clk_a);
		if (exp_due_q.size() != 0)
			stop_with_failure($sformatf("read of address 0x%h issued for cycle %0d never got rd_valid",
				exp_addr_q[0], exp_due_q[0] - LATENCY));
	endtask

	// compare process, outputs are stable on the falling edge
	always @(negedge clk_a) begin
		if (rd_valid === 1'b1) begin
			if (exp_due_q.size() == 0)
				stop_with_failure("rd_valid came without any read in flight");
			verify_latency(cycle, exp_due_q[0]);
			check_word("rd_data", rd_data, exp_data_q[0]);
			void'(exp_data_q.pop_front());
			void'(exp_due_q.pop_front());
			void'(exp_addr_q.pop_front());
		end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle) begin
			stop_with_failure($sformatf("no rd_valid for the read of address 0x%h in its cycle",
				exp_addr_q[0]));
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		int          i;
		rst_n   = 1'b0;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_en   = 1'b0;
		rd_addr = '0;

		// reset held 5 cycles, rd_valid quiet throughout and after
		for (i = 0; i < 5; i++) begin
			@(negedge clk_a);
			verify_strobe("rd_valid", rd_valid, 1'b0);
		end
		rst_n = 1'b1;
		for (i = 0; i < 4; i++) begin
			idle();
			verify_strobe("rd_valid", rd_valid, 1'b0);
		end

		// fill every address, then read all back to back
		for (i = 0; i < WORDS; i++) begin
			draw_random(r);
			step(1'b1, ADDR_W'(i), r[31:16], 1'b0, '0);
		end
		for (i = 0; i < WORDS; i++)
			step(1'b0, '0, '0, 1'b1, ADDR_W'(i));
		idle();
		wait_drain();

		// write then read next cycle, one address per bank
		for (i = 0; i < `BANK_COUNT; i++) begin
			draw_random(d);
			step(1'b1, ADDR_W'(i + 20), d[15:0], 1'b0, '0);
			step(1'b0, '0, '0, 1'b1, ADDR_W'(i + 20)); // sees the new word
		end
		idle();
		wait_drain();

		// same cycle collision returns the old word
		for (i = 0; i < `BANK_COUNT; i++) begin
			draw_random(d);
			step(1'b1, ADDR_W'(i + 40), d[31:16], 1'b1, ADDR_W'(i + 40));
		end
		idle();
		wait_drain();

		// random concurrent traffic
		for (i = 0; i < 300; i++) begin
			draw_random(r);
			draw_random(d);
			step(r[0], r[13:8], d[15:0], r[1], r[21:16]);
		end
		idle();
		wait_drain();

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
source/buf_addr_pkg.sv
source/buf_data_pkg.sv
source/bank_router.sv
source/dp_sram_bank.sv
source/read_collector.sv
source/banked_buffer_top.sv
tb/banked_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the banked buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f sim.f \
	--top-module banked_buffer_tb \
	-o banked_buffer_sim

./obj_dir/banked_buffer_sim
